// ==== include/genesis_defines.svh ====
////////////////////////////////////////
// shared constants for the cartridge control logic
// include wherever addresses, header offsets or ids are needed
////////////////////////////////////////

`ifndef GENESIS_DEFINES_SVH
`define GENESIS_DEFINES_SVH

// rom download bus
`define ROM_ADDR_W 25
`define ROM_DATA_W 16

// apb register map
`define REG_MULTITAP     32'h0000_0000
`define REG_OBJ_LIMIT    32'h0000_0030
`define REG_FM_EN        32'h0000_0040
`define REG_PSG_EN       32'h0000_0050
`define REG_CPU_TURBO    32'h00C0_0000
`define REG_AUDIO_FILTER 32'h00F0_0000
`define REG_REGION       32'h00E0_0000 // read only
`define REG_ROM_SIZE     32'h00E0_0004 // read only

// header byte offsets, word aligned
`define HDR_ID_0     25'h182
`define HDR_ID_1     25'h184
`define HDR_ID_2     25'h186
`define HDR_ID_3     25'h188
`define HDR_ID_4     25'h18A
`define HDR_ID_CHECK 25'h18C
`define HDR_REGION_A 25'h1F0
`define HDR_REGION_B 25'h1F2
`define HDR_END      25'h200

// settings after reset
`define RST_CPU_TURBO    2'd0
`define RST_MULTITAP     1'b0
`define RST_OBJ_LIMIT    1'b1
`define RST_FM_EN        1'b1
`define RST_PSG_EN       1'b1
`define RST_AUDIO_FILTER 2'd0

`define GUN_DELAY_DEFAULT 8'd44

// cartridge ids, 8 ascii characters each
`define CART_ID_SRAM_A   "T-081276"
`define CART_ID_SRAM_B   "T-81406 "
`define CART_ID_EEPROM_A "MK-1215 "
`define CART_ID_EEPROM_B "G-4060  "
`define CART_ID_NORAM    "T-113016"
`define CART_ID_FIFO     "T-89016 "
`define CART_ID_SVP      "MK-1229 "
`define CART_ID_FMBUSY   "T-35036 "
`define CART_ID_GUN_A    "T-95096-"
`define CART_ID_GUN_B    "MK-1533 "

`endif

// ==== source/genesis_pkg.sv ====
////////////////////////////////////////
// types shared by the cartridge control blocks
// modules pull these in by a wildcard import
////////////////////////////////////////

`default_nettype none

`include "genesis_defines.svh"

package genesis_pkg;

	// region code as seen by the console
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	// one word of the rom download stream, low byte is the even address
	typedef struct packed {
		logic                   valid;
		logic [`ROM_ADDR_W-1:0] addr;
		logic [`ROM_DATA_W-1:0] data;
	} rom_write_t;

	typedef struct packed {
		logic active; // download in progress
		logic start;  // one cycle at download begin
		logic finish; // one cycle at download end
	} load_status_t;

	typedef struct packed {
		region_e region;
		logic    export_mode; // anything but jp
		logic    hold;        // console kept in reset while region settles
	} region_info_t;

	// per-game fixups picked from the cartridge id
	typedef struct packed {
		logic       sram;
		logic       eeprom;
		logic       noram;
		logic       fifo;
		logic       svp;
		logic       fmbusy;
		logic       gun_type;
		logic [7:0] gun_delay;
	} cart_quirks_t;

	typedef struct packed {
		logic [1:0] cpu_turbo;
		logic       multitap;
		logic       obj_limit_high;
		logic       fm_enable;
		logic       psg_enable;
		logic [1:0] audio_filter;
	} core_settings_t;

	// console pad layout, msb first
	typedef struct packed {
		logic z;
		logic y;
		logic x;
		logic mode;
		logic start;
		logic b;
		logic c;
		logic a;
		logic up;
		logic down;
		logic left;
		logic right;
	} pad_word_t;

endpackage

`default_nettype wire

// ==== source/core_settings_regs.sv ====
////////////////////////////////////////
// apb slave holding the core settings
// zero wait states, status readback of region and rom size
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "genesis_defines.svh"

module core_settings_regs
	import genesis_pkg::*;
(
	input  wire                   clk_sys,
	input  wire                   arst_n,
	input  wire                   psel,
	input  wire                   penable,
	input  wire                   pwrite,
	input  wire  [31:0]           paddr,
	input  wire  [31:0]           pwdata,
	input  wire  region_info_t    region,
	input  wire  [`ROM_ADDR_W-1:0] rom_size,
	output logic [31:0]           prdata,
	output logic                  pready,
	output core_settings_t        settings
);

	logic access; // apb access phase
	logic wr_en;
	logic rd_en;

	assign access = psel & penable;
	assign wr_en  = access & pwrite;
	assign rd_en  = access & ~pwrite;
	assign pready = access; // never stretched

	////////////////////////////////////////
	// write side
	////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			settings.cpu_turbo      <= `RST_CPU_TURBO;
			settings.multitap       <= `RST_MULTITAP;
			settings.obj_limit_high <= `RST_OBJ_LIMIT;
			settings.fm_enable      <= `RST_FM_EN;
			settings.psg_enable     <= `RST_PSG_EN;
			settings.audio_filter   <= `RST_AUDIO_FILTER;
		end else if (wr_en) begin
			case (paddr)
				`REG_CPU_TURBO:    settings.cpu_turbo      <= pwdata[1:0];
				`REG_MULTITAP:     settings.multitap       <= pwdata[0];
				`REG_OBJ_LIMIT:    settings.obj_limit_high <= pwdata[0];
				`REG_FM_EN:        settings.fm_enable      <= pwdata[0];
				`REG_PSG_EN:       settings.psg_enable     <= pwdata[0];
				`REG_AUDIO_FILTER: settings.audio_filter   <= pwdata[1:0];
				default: ; // unmapped writes dropped
			endcase
		end
	end

	////////////////////////////////////////
	// read side
	////////////////////////////////////////

	always_comb begin
		prdata = '0;
		if (rd_en) begin
			case (paddr)
				`REG_REGION:   prdata = {30'd0, region.region};
				`REG_ROM_SIZE: prdata = {{(32-`ROM_ADDR_W){1'b0}}, rom_size};
				default:       prdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/cart_load_monitor.sv ====
////////////////////////////////////////
// download level tracking with start and finish pulses
// also captures the rom size when the download ends
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "genesis_defines.svh"

module cart_load_monitor
	import genesis_pkg::*;
(
	input  wire                    clk_sys,
	input  wire                    arst_n,
	input  wire                    load_start,
	input  wire                    load_done,
	input  wire  rom_write_t       rom_wr,
	output load_status_t           load_status,
	output logic [`ROM_ADDR_W-1:0] rom_size
);

	logic                   active_q;  // level one cycle back
	logic [`ROM_ADDR_W-1:0] last_addr; // address of last word written

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			load_status <= '0;
			active_q    <= 1'b0;
			rom_size    <= '0;
		end else begin
			if (load_start)
				load_status.active <= 1'b1;
			else if (load_done)
				load_status.active <= 1'b0;
			active_q           <= load_status.active;
			load_status.start  <= load_status.active & ~active_q;
			load_status.finish <= ~load_status.active & active_q;
			if (load_status.finish)
				rom_size <= last_addr + `ROM_ADDR_W'(2); // one word past the last
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_wr.valid && load_status.active)
			last_addr <= rom_wr.addr;
	end

endmodule

`default_nettype wire

// ==== source/cart_region_detect.sv ====
////////////////////////////////////////
// region detection from the cartridge header
// raises hold from header end until the download finishes
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "genesis_defines.svh"

module cart_region_detect
	import genesis_pkg::*;
(
	input  wire                clk_sys,
	input  wire                arst_n,
	input  wire  rom_write_t   rom_wr,
	input  wire  load_status_t load_status,
	output region_info_t       region
);

	logic       hdr_wr;      // header write during download
	logic [7:0] lo_byte;
	logic [7:0] hi_byte;
	logic [3:0] hex_val;     // 'A'..'F' mapped to 10..15
	logic [2:0] flags;       // {e, u, j}
	logic [2:0] flags_nxt;
	logic       hdr_ready;
	logic       hdr_ready_q;
	region_e    region_code;
	logic       hold;

	// one-hot {e, u, j} for a region letter, zero otherwise
	function automatic logic [2:0] letter_euj(input logic [7:0] c);
		return {c == "E", c == "U", c == "J"};
	endfunction

	assign hdr_wr  = rom_wr.valid & load_status.active;
	assign lo_byte = rom_wr.data[7:0];
	assign hi_byte = rom_wr.data[15:8];
	assign hex_val = lo_byte[3:0] - 4'd7;

	always_comb begin
		flags_nxt = flags;
		if (hdr_wr && rom_wr.addr == `HDR_REGION_A) begin
			if (|letter_euj(lo_byte))
				flags_nxt = flags_nxt | letter_euj(lo_byte);
			else if (lo_byte >= "0" && lo_byte <= "9")
				flags_nxt = {lo_byte[3], lo_byte[2], lo_byte[0]}; // new style bitmask
			else if (lo_byte >= "A" && lo_byte <= "F")
				flags_nxt = {hex_val[3], hex_val[2], hex_val[0]};
			flags_nxt = flags_nxt | letter_euj(hi_byte);
		end
		if (hdr_wr && rom_wr.addr == `HDR_REGION_B)
			flags_nxt = flags_nxt | letter_euj(lo_byte);
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			flags       <= '0;
			hdr_ready   <= 1'b0;
			hdr_ready_q <= 1'b0;
			region_code <= REGION_JP;
			hold        <= 1'b0;
		end else begin
			hdr_ready_q <= hdr_ready;
			flags       <= load_status.start ? 3'b000 : flags_nxt;

			if (load_status.finish)
				hdr_ready <= 1'b0;
			else if (hdr_wr && rom_wr.addr == `HDR_END)
				hdr_ready <= 1'b1;

			if (load_status.finish) begin
				hold <= 1'b0;
			end else if (hdr_ready && !hdr_ready_q) begin
				hold <= 1'b1;
				// us wins over eu, eu over jp, nothing at all means us
				if (flags[1])      region_code <= REGION_US;
				else if (flags[2]) region_code <= REGION_EU;
				else if (flags[0]) region_code <= REGION_JP;
				else               region_code <= REGION_US;
			end
		end
	end

	assign region.region      = region_code;
	assign region.export_mode = (region_code != REGION_JP);
	assign region.hold        = hold;

endmodule

`default_nettype wire

// ==== source/cart_id_quirks.sv ====
////////////////////////////////////////
// per-game quirk lookup by cartridge id
// the id comes from the header words at 0x182..0x18a
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "genesis_defines.svh"

module cart_id_quirks
	import genesis_pkg::*;
(
	input  wire                clk_sys,
	input  wire                arst_n,
	input  wire  rom_write_t   rom_wr,
	input  wire  load_status_t load_status,
	output cart_quirks_t       quirks
);

	logic         hdr_wr;
	logic [63:0]  cart_id;    // first character in the top byte
	logic         id_checked; // lookup done for this download
	cart_quirks_t id_match;

	assign hdr_wr = rom_wr.valid & load_status.active;

	////////////////////////////////////////
	// id assembly
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			case (rom_wr.addr)
				`HDR_ID_0: cart_id[63:56] <= rom_wr.data[15:8]; // odd byte only
				`HDR_ID_1: cart_id[55:40] <= {rom_wr.data[7:0], rom_wr.data[15:8]};
				`HDR_ID_2: cart_id[39:24] <= {rom_wr.data[7:0], rom_wr.data[15:8]};
				`HDR_ID_3: cart_id[23:8]  <= {rom_wr.data[7:0], rom_wr.data[15:8]};
				`HDR_ID_4: cart_id[7:0]   <= rom_wr.data[7:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// table
	////////////////////////////////////////

	always_comb begin
		id_match           = '0;
		id_match.gun_delay = `GUN_DELAY_DEFAULT;
		case (cart_id)
			`CART_ID_SRAM_A,
			`CART_ID_SRAM_B:   id_match.sram   = 1'b1;
			`CART_ID_EEPROM_A,
			`CART_ID_EEPROM_B: id_match.eeprom = 1'b1;
			`CART_ID_NORAM:    id_match.noram  = 1'b1; // fake ram check
			`CART_ID_FIFO:     id_match.fifo   = 1'b1;
			`CART_ID_SVP:      id_match.svp    = 1'b1;
			`CART_ID_FMBUSY:   id_match.fmbusy = 1'b1;
			`CART_ID_GUN_A: begin
				id_match.gun_type  = 1'b1;
				id_match.gun_delay = 8'd52;
			end
			`CART_ID_GUN_B: begin
				id_match.gun_type  = 1'b0;
				id_match.gun_delay = 8'd100;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			quirks           <= '0;
			quirks.gun_delay <= `GUN_DELAY_DEFAULT;
			id_checked       <= 1'b0;
		end else begin
			if (!load_status.active)
				id_checked <= 1'b0;
			else if (!id_checked)
				{quirks.sram, quirks.eeprom, quirks.noram,
				 quirks.fifo, quirks.svp, quirks.fmbusy} <= '0;

			if (hdr_wr && rom_wr.addr == `HDR_ID_CHECK) begin
				quirks     <= id_match; // id complete by now
				id_checked <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/pad_remap.sv ====
////////////////////////////////////////
// maps four 16-bit host pads onto the console layout
// one register stage
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pad_remap
	import genesis_pkg::*;
(
	input  wire              clk_sys,
	input  wire              arst_n,
	input  wire  [3:0][15:0] pad_keys,
	output pad_word_t [3:0]  pads
);

	// host key bits -> console buttons
	function automatic pad_word_t remap(input logic [15:0] k);
		return '{
			z:     k[9],  // r1
			y:     k[6],  // face x
			x:     k[8],  // l1
			mode:  k[14], // select
			start: k[15],
			b:     k[4],
			c:     k[5],
			a:     k[7],
			up:    k[0],
			down:  k[1],
			left:  k[2],
			right: k[3]
		};
	endfunction

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			pads <= '0;
		end else begin
			for (int i = 0; i < 4; i++)
				pads[i] <= remap(pad_keys[i]);
		end
	end

endmodule

`default_nettype wire

// ==== source/genesis_core_top.sv ====
////////////////////////////////////////
// cartridge side control of the console core
// settings bus, download tracking, header decode, pads
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "genesis_defines.svh"

module genesis_core_top
	import genesis_pkg::*;
(
	input  wire                  clk_sys,
	input  wire                  arst_n,
	// apb settings bus
	input  wire                  psel,
	input  wire                  penable,
	input  wire                  pwrite,
	input  wire  [31:0]          paddr,
	input  wire  [31:0]          pwdata,
	output logic [31:0]          prdata,
	output logic                 pready,
	// rom download
	input  wire                  load_start,
	input  wire                  load_done,
	input  wire  rom_write_t     rom_wr,
	// controllers
	input  wire  [3:0][15:0]     pad_keys,
	// towards the console
	output core_settings_t       settings,
	output region_info_t         region_out,
	output cart_quirks_t         quirks,
	output pad_word_t [3:0]      pads
);

	load_status_t           load_status;
	logic [`ROM_ADDR_W-1:0] rom_size;

	core_settings_regs settings_i (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.region   (region_out),
		.rom_size (rom_size),
		.prdata   (prdata),
		.pready   (pready),
		.settings (settings)
	);

	cart_load_monitor load_i (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.load_start  (load_start),
		.load_done   (load_done),
		.rom_wr      (rom_wr),
		.load_status (load_status),
		.rom_size    (rom_size)
	);

	cart_region_detect region_i (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.rom_wr      (rom_wr),
		.load_status (load_status),
		.region      (region_out)
	);

	cart_id_quirks quirks_i (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.rom_wr      (rom_wr),
		.load_status (load_status),
		.quirks      (quirks)
	);

	pad_remap pads_i (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.pad_keys (pad_keys),
		.pads     (pads)
	);

endmodule

`default_nettype wire

// ==== verif/tb_genesis_core.sv ====
////////////////////////////////////////
// self-checking testbench for the console core top level
// checks reset values and apb settings, then runs a cartridge table
// through the download path and finishes with the pad remap
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "genesis_defines.svh"

module tb_genesis_core
	import genesis_pkg::*;
();

	// one cartridge per row with hand-worked expected values
	typedef struct packed {
		logic [15:0]  region_a; // header word at 0x1f0 as {high byte, low byte}
		logic [15:0]  region_b; // header word at 0x1f2
		logic [63:0]  id;
		logic [15:0]  nwords;
		region_e      region;
		cart_quirks_t quirks;   // {sram..fmbusy, gun_type, gun_delay}
		logic [24:0]  rom_size;
	} cart_row_t;

	localparam int NROWS   = 11;
	localparam int END_IDX = `HDR_END / 2; // word index of the header end

	localparam core_settings_t SETTINGS_RESET = '{cpu_turbo: 2'd0, multitap: 1'b0,
		obj_limit_high: 1'b1, fm_enable: 1'b1, psg_enable: 1'b1, audio_filter: 2'd0};

	cart_row_t rows [NROWS] = '{
		'{16'h554A, 16'h2020, "T-081276", 16'd260, REGION_US, {7'b1000000, 8'd44}, 25'h208},
		'{16'h2045, 16'h2020, "MK-1215 ", 16'd300, REGION_EU, {7'b0100000, 8'd44}, 25'h258},
		'{16'h204A, 16'h2020, "T-95096-", 16'd264, REGION_JP, {7'b0000001, 8'd52}, 25'h210},
		'{16'h2038, 16'h2020, "MK-1229 ", 16'd320, REGION_EU, {7'b0000100, 8'd44}, 25'h280},
		'{16'h2043, 16'h2020, "MK-1533 ", 16'd270, REGION_US, {7'b0000000, 8'd100}, 25'h21C},
		'{16'h2031, 16'h2045, "T-35036 ", 16'd512, REGION_EU, {7'b0000010, 8'd44}, 25'h400},
		'{16'h2020, 16'h2020, "UNKNOWN1", 16'd261, REGION_US, {7'b0000000, 8'd44}, 25'h20A},
		'{16'h454A, 16'h2020, "T-113016", 16'd280, REGION_EU, {7'b0010000, 8'd44}, 25'h230},
		'{16'h2055, 16'h2020, "T-89016 ", 16'd258, REGION_US, {7'b0001000, 8'd44}, 25'h204},
		'{16'h2041, 16'h2020, "T-81406 ", 16'd290, REGION_EU, {7'b1000000, 8'd44}, 25'h244},
		'{16'h2034, 16'h2020, "G-4060  ", 16'd384, REGION_US, {7'b0100000, 8'd44}, 25'h300}
	};

	logic [31:0] set_addr [6] = '{`REG_MULTITAP, `REG_OBJ_LIMIT, `REG_FM_EN,
		`REG_PSG_EN, `REG_CPU_TURBO, `REG_AUDIO_FILTER};

	logic             clk_sys;
	logic             arst_n;
	logic             psel;
	logic             penable;
	logic             pwrite;
	logic [31:0]      paddr;
	logic [31:0]      pwdata;
	logic [31:0]      prdata;
	logic             pready;
	logic             load_start;
	logic             load_done;
	rom_write_t       rom_wr;
	logic [3:0][15:0] pad_keys;
	core_settings_t   settings;
	region_info_t     region_out;
	cart_quirks_t     quirks;
	pad_word_t [3:0]  pads;

	core_settings_t   exp_set;
	logic [31:0]      rdata;
	logic [31:0]      wdata;
	logic [3:0][15:0] prev_keys;
	logic [3:0][15:0] next_keys;
	int               errors;
	int               test_errors;
	int               tests_run;
	int               tests_failed;

	genesis_core_top dut_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.load_start (load_start),
		.load_done  (load_done),
		.rom_wr     (rom_wr),
		.pad_keys   (pad_keys),
		.settings   (settings),
		.region_out (region_out),
		.quirks     (quirks),
		.pads       (pads)
	);

	always #2 clk_sys = ~clk_sys; // 4 ns period

	////////////////////////////////////////
	// reference models and helpers
	////////////////////////////////////////

	// console layout from the host key bits from z down to right
	function automatic pad_word_t expected_pad(input logic [15:0] k);
		return {k[9], k[6], k[8], k[14], k[15], k[4], k[5], k[7], k[0], k[1], k[2], k[3]};
	endfunction

	function automatic core_settings_t apply_write(input core_settings_t s,
			input logic [31:0] a, input logic [31:0] d);
		core_settings_t r;
		r = s;
		case (a)
			`REG_CPU_TURBO:    r.cpu_turbo      = d[1:0];
			`REG_MULTITAP:     r.multitap       = d[0];
			`REG_OBJ_LIMIT:    r.obj_limit_high = d[0];
			`REG_FM_EN:        r.fm_enable      = d[0];
			`REG_PSG_EN:       r.psg_enable     = d[0];
			`REG_AUDIO_FILTER: r.audio_filter   = d[1:0];
			default: ;
		endcase
		return r;
	endfunction

	// id text sits at bytes 0x183..0x18a with the even byte in the low half
	function automatic logic [15:0] header_word(input cart_row_t row,
			input logic [24:0] a, input logic [15:0] filler);
		case (a)
			`HDR_ID_0:     return {row.id[63:56], 8'h20};
			`HDR_ID_1:     return {row.id[47:40], row.id[55:48]};
			`HDR_ID_2:     return {row.id[31:24], row.id[39:32]};
			`HDR_ID_3:     return {row.id[15:8], row.id[23:16]};
			`HDR_ID_4:     return {8'h2D, row.id[7:0]};
			`HDR_ID_CHECK: return 16'h3030;
			`HDR_REGION_A: return row.region_a;
			`HDR_REGION_B: return row.region_b;
			default:       return filler;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			$display("ERR %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic start_test();
		test_errors = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_errors) begin
			tests_failed++;
			$display("test %s: FAIL, %0d errors", name, errors - test_errors);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	////////////////////////////////////////
	// bus drivers
	////////////////////////////////////////

	task automatic apb_transfer(input logic is_write, input logic [31:0] addr,
			input logic [31:0] data_in, output logic [31:0] data_out);
		int waits;
		waits = 0;
		@(posedge clk_sys);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= is_write;
		paddr   <= addr;
		pwdata  <= data_in;
		@(posedge clk_sys);
		penable <= 1'b1; // access phase
		@(negedge clk_sys);
		while (!pready && waits < 16) begin
			@(negedge clk_sys);
			waits++;
		end
		assert (pready) else begin
			$display("APB access to %h timed out waiting for PREADY", addr);
			errors++;
		end
		data_out = prdata;
		@(posedge clk_sys);
		psel    <= 1'b0;
		penable <= 1'b0;
		@(negedge clk_sys);
	endtask

	// full download of one cartridge with hold checked every cycle
	task automatic download(input cart_row_t row);
		logic [24:0] word_addr;
		@(posedge clk_sys);
		load_start <= 1'b1;
		@(posedge clk_sys);
		load_start <= 1'b0;
		@(posedge clk_sys); // let the start pulse clear the region flags
		for (int i = 0; i < int'(row.nwords); i++) begin
			@(posedge clk_sys);
			word_addr = 25'(2 * i);
			rom_wr <= '{valid: 1'b1, addr: word_addr,
				data: header_word(row, word_addr, 16'($urandom))};
			@(negedge clk_sys);
			check_value("region_out.hold", 64'(region_out.hold), 64'(i >= END_IDX + 2));
		end
		@(posedge clk_sys);
		rom_wr    <= '0;
		load_done <= 1'b1;
		@(negedge clk_sys);
		check_value("region_out.hold", 64'(region_out.hold), 64'(1));
		@(posedge clk_sys);
		load_done <= 1'b0;
		@(negedge clk_sys);
		check_value("region_out.hold", 64'(region_out.hold), 64'(1));
		@(negedge clk_sys);
		check_value("region_out.hold", 64'(region_out.hold), 64'(1));
		@(negedge clk_sys); // 3 cycles after load_done
		check_value("region_out.hold", 64'(region_out.hold), 64'(0));
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		clk_sys      = 1'b0;
		arst_n       = 1'b0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		load_start   = 1'b0;
		load_done    = 1'b0;
		rom_wr       = '0;
		pad_keys     = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		void'($urandom(1058));
		repeat (8) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(negedge clk_sys);

		start_test();
		check_value("settings", 64'(settings), 64'(SETTINGS_RESET));
		check_value("region_out", 64'(region_out), 64'({REGION_JP, 1'b0, 1'b0}));
		check_value("quirks", 64'(quirks), 64'({7'd0, `GUN_DELAY_DEFAULT}));
		check_value("pads", 64'(pads), 64'(0));
		end_test("reset values");

		start_test();
		exp_set = SETTINGS_RESET;
		for (int n = 0; n < 6; n++) begin
			wdata = $urandom;
			for (int k = 0; k < 2; k++) begin
				exp_set = apply_write(exp_set, set_addr[n], wdata);
				apb_transfer(1'b1, set_addr[n], wdata, rdata);
				check_value("settings", 64'(settings), 64'(exp_set));
				wdata = ~wdata; // every field bit takes both values
			end
		end
		apb_transfer(1'b1, 32'h0000_0010, 32'hFFFF_FFFF, rdata); // unmapped
		check_value("settings", 64'(settings), 64'(exp_set));
		apb_transfer(1'b1, 32'h0000_0010, 32'h0000_0000, rdata);
		check_value("settings", 64'(settings), 64'(exp_set));
		end_test("settings writes");

		for (int r = 0; r < NROWS; r++) begin
			start_test();
			download(rows[r]);
			check_value("region_out.region", 64'(region_out.region), 64'(rows[r].region));
			check_value("region_out.export_mode", 64'(region_out.export_mode),
				64'(rows[r].region != REGION_JP));
			check_value("quirks", 64'(quirks), 64'(rows[r].quirks));
			apb_transfer(1'b0, `REG_REGION, 32'd0, rdata);
			check_value("prdata region", 64'(rdata), 64'(rows[r].region));
			apb_transfer(1'b0, `REG_ROM_SIZE, 32'd0, rdata);
			check_value("prdata rom_size", 64'(rdata), 64'(rows[r].rom_size));
			end_test($sformatf("cartridge %0d", r));
		end

		start_test();
		prev_keys = pad_keys;
		for (int n = 0; n < 16; n++) begin
			@(posedge clk_sys);
			for (int p = 0; p < 4; p++)
				next_keys[p] = 16'($urandom);
			pad_keys <= next_keys;
			@(negedge clk_sys);
			// output still shows the keys from one edge back
			for (int p = 0; p < 4; p++)
				check_value($sformatf("pads[%0d]", p), 64'(pads[p]),
					64'(expected_pad(prev_keys[p])));
			prev_keys = next_keys;
		end
		end_test("pad remap");

		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
source/genesis_pkg.sv
source/core_settings_regs.sv
source/cart_load_monitor.sv
source/cart_region_detect.sv
source/cart_id_quirks.sv
source/pad_remap.sv
source/genesis_core_top.sv
verif/tb_genesis_core.sv

// ==== Makefile ====
TOP = tb_genesis_core
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o sim_bin

run: build
	./obj_dir/sim_bin > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "Testbench failed" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module genesis_core_top

clean:
	rm -rf obj_dir $(LOG)
